/* Makefile */
# Verilator lint, simulation and clean for the bus splitter

TB_TOP := bus_split_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f verilog.f --top-module bus_split_top

# the run's exit status carries pass or fail
sim:
	verilator --binary --timing --assert -j 0 -f verilog.f \
		--top-module $(TB_TOP) -Mdir obj_dir
	./obj_dir/V$(TB_TOP)

clean:
	rm -rf obj_dir

/* bench/bus_split_tb.sv */
// clock, reset, random master, slave models, scoreboard and assertions for the bus splitter
`timescale 1ns/1ps
`default_nettype none

module bus_split_tb;

	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_REQ      = 400;
	// 20 cycles per request is far above the worst stall and ack delay
	localparam int WATCHDOG_NS  = (NUM_REQ * 20 + RESET_CYCLES) * CLK_PERIOD;
	// target index of the no-slave error responder
	localparam logic [2:0] ERR_TGT = 3'(addr_map_pkg::NUM_SLAVES);

	// expected outcome of one accepted request
	typedef struct packed {
		bus_pkg::bus_req_t req;
		logic [2:0]        tgt;
	} exp_t;

	logic                                i_clk = 1'b0;
	logic                                i_reset = 1'b1;
	logic                                i_valid = 1'b0;
	bus_pkg::bus_req_t                   i_req = '0;
	logic                                o_stall;
	logic                                o_ack;
	logic                                o_err;
	logic [bus_pkg::DATA_W-1:0]          o_rdata;
	logic [addr_map_pkg::NUM_SLAVES-1:0] o_slv_valid;
	bus_pkg::bus_req_t                   o_slv_req;
	logic [addr_map_pkg::NUM_SLAVES-1:0] i_slv_stall = '0;
	logic [addr_map_pkg::NUM_SLAVES-1:0] i_slv_ack = '0;
	bus_pkg::slv_rdata_t                 i_slv_rdata = '0;

	// requests not yet handed to a slave or the error responder
	exp_t send_q[$];
	// requests still owed a response in acceptance order
	exp_t resp_q[$];
	exp_t ent;
	// per-slave model state holding the address and ack-ready cycle of each request
	logic [31:0] slv_addr_q [addr_map_pkg::NUM_SLAVES][$];
	int unsigned slv_ready_q [addr_map_pkg::NUM_SLAVES][$];

	int unsigned cycle = 0;
	int unsigned reset_seen = 0;
	int unsigned n_started = 0;
	int unsigned n_accepted = 0;
	int unsigned n_sent = 0;
	int unsigned n_ack = 0;
	int unsigned n_err = 0;

	bus_split_top bus_split_top_i (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_valid     (i_valid),
		.i_req       (i_req),
		.o_stall     (o_stall),
		.o_ack       (o_ack),
		.o_err       (o_err),
		.o_rdata     (o_rdata),
		.o_slv_valid (o_slv_valid),
		.o_slv_req   (o_slv_req),
		.i_slv_stall (i_slv_stall),
		.i_slv_ack   (i_slv_ack),
		.i_slv_rdata (i_slv_rdata)
	);

	always #(CLK_PERIOD / 2) i_clk = ~i_clk;

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	// a region matches when masked address equals masked base and the direction is allowed
	function automatic logic [2:0] match_target(input bus_pkg::bus_req_t req);
		logic [2:0] tgt;
		logic       allowed;
		tgt = ERR_TGT;
		for (int k = 0; k < addr_map_pkg::NUM_SLAVES; k++)
		begin
			allowed = req.we ? addr_map_pkg::WRITE_ALLOWED[k]
				: addr_map_pkg::READ_ALLOWED[k];
			if (((req.addr & addr_map_pkg::SLAVE_MASK[k])
				== (addr_map_pkg::SLAVE_BASE[k] & addr_map_pkg::SLAVE_MASK[k])) && allowed)
			begin
				tgt = 3'(k);
			end
		end
		return tgt;
	endfunction

	// slave k answers with the address xor (k+1) * 0x1111_1111
	function automatic logic [31:0] slave_rdata(input logic [31:0] addr, input int k);
		return addr ^ (32'(k + 1) * 32'h1111_1111);
	endfunction

	// regions 0 to 3 land inside a slave window
	// region 4 falls just outside slave 2 and region 5 anywhere
	function automatic bus_pkg::bus_req_t random_request();
		bus_pkg::bus_req_t req;
		logic [2:0]        region;
		region    = 3'($urandom_range(0, 5));
		req.we    = 1'($urandom_range(0, 1));
		req.wdata = $urandom;
		req.sel   = 4'($urandom);
		case (region)
			3'd0, 3'd1, 3'd2, 3'd3:
				req.addr = (addr_map_pkg::SLAVE_BASE[region[1:0]]
					& addr_map_pkg::SLAVE_MASK[region[1:0]])
					| ($urandom & ~addr_map_pkg::SLAVE_MASK[region[1:0]]);
			3'd4:
				req.addr = 32'h2000_0000 | (32'($urandom_range(1, 15)) << 24)
					| ($urandom & 32'h00FF_FFFF);
			default:
				req.addr = $urandom;
		endcase
		return req;
	endfunction

	task automatic fail_run(input string msg);
		$display("** Error at %0t ns: %s", $time, msg);
		$display("Some tests failed");
		$fatal(1, "stopped at first error");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// master, slave models and scoreboard on the rising edge
	////////////////////////////////////////////////////////////////////////////

	always @(posedge i_clk)
	begin
		if (i_reset)
		begin
			// registers are only defined after the first reset edge
			if (reset_seen > 0)
			begin
				assert (o_slv_valid == '0 && !o_ack && !o_err)
				else fail_run("slave strobe or response active during reset");
			end
			reset_seen++;
		end
		else
		begin
			cycle++;
			assert (!(o_ack && o_err))
			else fail_run("ack and error in the same cycle");

			// responses must match the oldest outstanding request
			if (o_ack)
			begin
				assert (resp_q.size() > 0 && resp_q[0].tgt != ERR_TGT)
				else fail_run("ack with no slave request at the queue head");
				ent = resp_q.pop_front();
				assert (i_slv_ack[ent.tgt[1:0]])
				else fail_run($sformatf("ack not from expected slave %0d", ent.tgt));
				if (!ent.req.we)
				begin
					assert (o_rdata == slave_rdata(ent.req.addr, int'(ent.tgt)))
					else fail_run($sformatf("read data %h, expected %h", o_rdata,
						slave_rdata(ent.req.addr, int'(ent.tgt))));
				end
				n_ack++;
			end
			if (o_err)
			begin
				assert (resp_q.size() > 0 && resp_q[0].tgt == ERR_TGT)
				else fail_run("bus error where a slave response was expected");
				void'(resp_q.pop_front());
				// the error request leaves the unsent queue with its response
				void'(send_q.pop_front());
				n_err++;
			end

			// slave strobes go to the matched slave with the oldest unsent request
			if (o_slv_valid != '0)
			begin
				assert ($onehot(o_slv_valid))
				else fail_run($sformatf("strobe %b not one-hot", o_slv_valid));
				assert (send_q.size() > 0)
				else fail_run("strobe with no request pending");
				assert (send_q[0].tgt != ERR_TGT && o_slv_valid == (4'b1 << send_q[0].tgt))
				else fail_run($sformatf("strobe %b, expected target %0d",
					o_slv_valid, send_q[0].tgt));
				assert (o_slv_req == send_q[0].req)
				else fail_run($sformatf("slave request %h, expected %h",
					o_slv_req, send_q[0].req));
				if ((o_slv_valid & ~i_slv_stall) != '0)
				begin
					ent = send_q.pop_front();
					slv_addr_q[ent.tgt[1:0]].push_back(ent.req.addr);
					slv_ready_q[ent.tgt[1:0]].push_back(cycle + $urandom_range(1, 3));
					n_sent++;
				end
			end

			// slave models ack in order once the drawn delay has passed
			for (int k = 0; k < addr_map_pkg::NUM_SLAVES; k++)
			begin
				i_slv_ack[k] <= 1'b0;
				if (slv_addr_q[k].size() > 0 && slv_ready_q[k][0] <= cycle)
				begin
					i_slv_ack[k]   <= 1'b1;
					i_slv_rdata[k] <= slave_rdata(slv_addr_q[k].pop_front(), k);
					void'(slv_ready_q[k].pop_front());
				end
				i_slv_stall[k] <= ($urandom_range(0, 3) == 0);
			end

			// master holds its request while stalled
			if (i_valid && !o_stall)
			begin
				ent.req = i_req;
				ent.tgt = match_target(i_req);
				send_q.push_back(ent);
				resp_q.push_back(ent);
				n_accepted++;
			end
			if (!i_valid || !o_stall)
			begin
				if (n_started < NUM_REQ && $urandom_range(0, 3) != 0)
				begin
					i_valid <= 1'b1;
					i_req   <= random_request();
					n_started++;
				end
				else
				begin
					i_valid <= 1'b0;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// run control
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		void'($urandom(32'h84a5));
		repeat (RESET_CYCLES) @(posedge i_clk);
		i_reset <= 1'b0;
		while (n_ack + n_err < NUM_REQ) @(posedge i_clk);
		// a few idle cycles so a stray response would still show up
		repeat (8) @(posedge i_clk);
		assert (n_accepted == NUM_REQ && n_sent + n_err == NUM_REQ && n_ack == n_sent)
		else fail_run($sformatf("counts accepted %0d sent %0d acked %0d errors %0d",
			n_accepted, n_sent, n_ack, n_err));
		assert (send_q.size() == 0 && resp_q.size() == 0)
		else fail_run("scoreboard not empty at the end of the run");
		$display("All tests passed");
		$finish;
	end

	// watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the run hung with %0d of %0d responses seen",
			n_ack + n_err, NUM_REQ);
		$display("Some tests failed");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

/* common/addr_map_pkg.sv */
// address map package: slave count, region bases and masks, direction rules, pending limit
`default_nettype none

package addr_map_pkg;

	//////////////////////////////////////////////////////////////////////////////
	// slave regions
	//////////////////////////////////////////////////////////////////////////////

	// number of real slave ports, the no-slave error target sits above these
	localparam int NUM_SLAVES = 4;

	// width of a slave index
	localparam int SLV_IDX_W = $clog2(NUM_SLAVES);

	// region base words, index 0 is the rightmost entry
	localparam logic [NUM_SLAVES-1:0][31:0] SLAVE_BASE = {
		32'h4000_0000,
		32'h2000_0000,
		32'h1000_0000,
		32'h0000_0000
	};

	// address bits that take part in the match for each region
	// slave 2 is a narrow 16 MB window, the rest take 256 MB
	localparam logic [NUM_SLAVES-1:0][31:0] SLAVE_MASK = {
		32'hF000_0000,
		32'hFF00_0000,
		32'hF000_0000,
		32'hF000_0000
	};

	//////////////////////////////////////////////////////////////////////////////
	// direction rules
	//////////////////////////////////////////////////////////////////////////////

	// every slave answers reads
	localparam logic [NUM_SLAVES-1:0] READ_ALLOWED = 4'b1111;

	// slave 3 is read-only, a write there becomes a bus error
	localparam logic [NUM_SLAVES-1:0] WRITE_ALLOWED = 4'b0111;

	// limit on requests in flight to one slave
	localparam int MAX_PENDING = 4;

	// pending counter must reach MAX_PENDING itself
	localparam int PEND_W = 3;

endpackage

`default_nettype wire

/* common/bus_pkg.sv */
// bus package: address and data widths, request struct, per-slave read-data array
`default_nettype none

package bus_pkg;

	//////////////////////////////////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////////////////////////////////

	// byte address
	localparam int ADDR_W = 32;

	// one bus word
	localparam int DATA_W = 32;

	// one select bit per byte lane
	localparam int SEL_W = DATA_W / 8;

	//////////////////////////////////////////////////////////////////////////////
	// request and response types
	//////////////////////////////////////////////////////////////////////////////

	// one pipelined request, 1 + 32 + 32 + 4 = 69 bits
	typedef struct packed {
		// high for a write, low for a read
		logic              we;
		logic [ADDR_W-1:0] addr;
		// ignored by the slave on reads
		logic [DATA_W-1:0] wdata;
		// byte lanes taking part in a write
		logic [SEL_W-1:0]  sel;
	} bus_req_t;

	// read-data word from each slave port, slave 0 in the low word
	typedef logic [addr_map_pkg::NUM_SLAVES-1:0][DATA_W-1:0] slv_rdata_t;

endpackage

`default_nettype wire

/* decode/addr_decode.sv */
// addr_decode: registered address and direction decoder with one-hot slave target
`timescale 1ns/1ps
`default_nettype none

module addr_decode (
	input  wire                                 i_clk,
	input  wire                                 i_reset,
	// master side
	input  wire                                 i_valid,
	output logic                                o_stall,
	input  bus_pkg::bus_req_t                   i_req,
	// router side
	output logic                                o_valid,
	input  wire                                 i_stall,
	output bus_pkg::bus_req_t                   o_req,
	output logic [addr_map_pkg::NUM_SLAVES:0]   o_target
);

	//////////////////////////////////////////////////////////////////////////////
	// region match
	//////////////////////////////////////////////////////////////////////////////

	// per-region hit after the direction check
	logic [addr_map_pkg::NUM_SLAVES-1:0] hit;

	// hit plus the no-slave bit on top
	logic [addr_map_pkg::NUM_SLAVES:0] target;

	always_comb
	begin
		for (int k = 0; k < addr_map_pkg::NUM_SLAVES; k++)
		begin
			// address must agree with the base on every masked bit
			// and the region must accept this direction
			hit[k] = (((i_req.addr ^ addr_map_pkg::SLAVE_BASE[k])
				& addr_map_pkg::SLAVE_MASK[k]) == '0)
				&& (i_req.we ? addr_map_pkg::WRITE_ALLOWED[k]
					: addr_map_pkg::READ_ALLOWED[k]);
		end

		// regions never overlap, so at most one hit bit is set
		// nothing matched means the request ends in a bus error
		target = {~|hit, hit};
	end

	//////////////////////////////////////////////////////////////////////////////
	// output register
	//////////////////////////////////////////////////////////////////////////////

	// full and not drained this cycle, so nothing new may enter
	assign o_stall = o_valid && i_stall;

	// valid flag
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_valid <= 1'b0;
		end
		else if (!o_stall)
		begin
			o_valid <= i_valid;
		end
	end

	// request and target, loaded when the register is empty or draining
	// and frozen while the router stalls
	always_ff @(posedge i_clk)
	begin
		if (!o_stall)
		begin
			o_req    <= i_req;
			o_target <= target;
		end
	end

endmodule

`default_nettype wire

/* logic/bus_route.sv */
// bus_route: request fan-out to slaves, pending count, in-order response return, error responder
`timescale 1ns/1ps
`default_nettype none

module bus_route (
	input  wire                                     i_clk,
	input  wire                                     i_reset,
	// decoded request from addr_decode
	input  wire                                     i_valid,
	output logic                                    o_stall,
	input  bus_pkg::bus_req_t                       i_req,
	input  wire  [addr_map_pkg::NUM_SLAVES:0]       i_target,
	// slave ports
	output logic [addr_map_pkg::NUM_SLAVES-1:0]     o_slv_valid,
	output bus_pkg::bus_req_t                       o_slv_req,
	input  wire  [addr_map_pkg::NUM_SLAVES-1:0]     i_slv_stall,
	input  wire  [addr_map_pkg::NUM_SLAVES-1:0]     i_slv_ack,
	input  bus_pkg::slv_rdata_t                     i_slv_rdata,
	// responses to the master
	output logic                                    o_ack,
	output logic                                    o_err,
	output logic [bus_pkg::DATA_W-1:0]              o_rdata
);

	//////////////////////////////////////////////////////////////////////////////
	// state and request decode
	//////////////////////////////////////////////////////////////////////////////

	// slave that owns every outstanding request
	logic [addr_map_pkg::SLV_IDX_W-1:0] cur_slv;

	// requests accepted by cur_slv and not yet acked
	logic [addr_map_pkg::PEND_W-1:0] pending;

	// error response due next cycle
	logic err_q;

	// index of the one-hot slave bit of the incoming request
	logic [addr_map_pkg::SLV_IDX_W-1:0] tgt_idx;

	// request goes to the no-slave target
	logic tgt_err;

	logic idle;
	logic blocked;
	logic accept_slv;
	logic accept_err;

	always_comb
	begin
		tgt_idx = '0;
		for (int k = 0; k < addr_map_pkg::NUM_SLAVES; k++)
		begin
			if (i_target[k])
			begin
				tgt_idx = addr_map_pkg::SLV_IDX_W'(k);
			end
		end
	end

	assign tgt_err = i_target[addr_map_pkg::NUM_SLAVES];
	assign idle    = (pending == '0);

	// a switch of slave waits for the old one to drain, which keeps order
	// a full counter holds off more requests to the same slave
	assign blocked = (!idle && (cur_slv != tgt_idx))
		|| (pending == addr_map_pkg::PEND_W'(addr_map_pkg::MAX_PENDING));

	//////////////////////////////////////////////////////////////////////////////
	// request fan-out
	//////////////////////////////////////////////////////////////////////////////

	// one shared request bus, only the strobes differ
	assign o_slv_req = i_req;

	always_comb
	begin
		for (int k = 0; k < addr_map_pkg::NUM_SLAVES; k++)
		begin
			o_slv_valid[k] = i_valid && i_target[k] && !blocked;
		end
	end

	assign accept_slv = i_valid && !tgt_err && !blocked && !i_slv_stall[tgt_idx];

	// errors are answered only once every earlier slave response is out
	assign accept_err = i_valid && tgt_err && idle;

	// stall back to the decoder for whatever kept the request from leaving
	assign o_stall = i_valid && !(accept_slv || accept_err);

	//////////////////////////////////////////////////////////////////////////////
	// response return
	//////////////////////////////////////////////////////////////////////////////

	// only the current slave can owe a response
	assign o_ack   = i_slv_ack[cur_slv];
	assign o_rdata = i_slv_rdata[cur_slv];
	assign o_err   = err_q;

	// pending counter, acceptance and ack may land in the same cycle
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			pending <= '0;
		end
		else if (accept_slv && !o_ack)
		begin
			pending <= pending + 1'b1;
		end
		else if (!accept_slv && o_ack)
		begin
			pending <= pending - 1'b1;
		end
	end

	// current slave follows the latest accepted request
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			cur_slv <= '0;
		end
		else if (accept_slv)
		begin
			cur_slv <= tgt_idx;
		end
	end

	// error responder, one clock after acceptance
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			err_q <= 1'b0;
		end
		else
		begin
			err_q <= accept_err;
		end
	end

endmodule

`default_nettype wire

/* logic/bus_split_top.sv */
// bus_split_top: single-master splitter built from the address decoder and the router
`timescale 1ns/1ps
`default_nettype none

module bus_split_top (
	input  wire                                     i_clk,
	input  wire                                     i_reset,
	// master port
	input  wire                                     i_valid,
	input  bus_pkg::bus_req_t                       i_req,
	output logic                                    o_stall,
	output logic                                    o_ack,
	output logic                                    o_err,
	output logic [bus_pkg::DATA_W-1:0]              o_rdata,
	// slave ports
	output logic [addr_map_pkg::NUM_SLAVES-1:0]     o_slv_valid,
	output bus_pkg::bus_req_t                       o_slv_req,
	input  wire  [addr_map_pkg::NUM_SLAVES-1:0]     i_slv_stall,
	input  wire  [addr_map_pkg::NUM_SLAVES-1:0]     i_slv_ack,
	input  bus_pkg::slv_rdata_t                     i_slv_rdata
);

	// decoder to router handshake
	logic                              dec_valid;
	logic                              dec_stall;
	bus_pkg::bus_req_t                 dec_req;
	logic [addr_map_pkg::NUM_SLAVES:0] dec_target;

	// one register stage of address decode
	addr_decode addr_decode_i (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_valid  (i_valid),
		.o_stall  (o_stall),
		.i_req    (i_req),
		.o_valid  (dec_valid),
		.i_stall  (dec_stall),
		.o_req    (dec_req),
		.o_target (dec_target)
	);

	// fan-out and in-order response return
	bus_route bus_route_i (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_valid     (dec_valid),
		.o_stall     (dec_stall),
		.i_req       (dec_req),
		.i_target    (dec_target),
		.o_slv_valid (o_slv_valid),
		.o_slv_req   (o_slv_req),
		.i_slv_stall (i_slv_stall),
		.i_slv_ack   (i_slv_ack),
		.i_slv_rdata (i_slv_rdata),
		.o_ack       (o_ack),
		.o_err       (o_err),
		.o_rdata     (o_rdata)
	);

endmodule

`default_nettype wire

/* verilog.f */
common/addr_map_pkg.sv
common/bus_pkg.sv
decode/addr_decode.sv
logic/bus_route.sv
logic/bus_split_top.sv
bench/bus_split_tb.sv
